// File: vector_decoder.f
+incdir+hdl
hdl/vdec_pkg.sv
hdl/apu_sequencer.sv
hdl/vop_decoder.sv
hdl/vreg_index_gen.sv
hdl/vector_decoder.sv
verif/vdec_checks.sv
verif/tb_vector_decoder.sv

// File: Makefile
SOURCES := $(wildcard hdl/*.sv hdl/*.svh verif/*.sv) vector_decoder.f

.PHONY: all run clean

all: obj_dir/Vtb_vector_decoder

obj_dir/Vtb_vector_decoder: $(SOURCES)
	verilator --binary --timing --assert -f vector_decoder.f \
		--top-module tb_vector_decoder -o Vtb_vector_decoder

run: obj_dir/Vtb_vector_decoder
	./obj_dir/Vtb_vector_decoder

clean:
	rm -rf obj_dir

// File: verif/tb_vector_decoder.sv
// vector decoder testbench driving APU requests with random vl, vsew and stalls
`include "vdec_defines.svh"

module tb_vector_decoder;

timeunit 1ns;
timeprecision 1ps;

logic                          clk;
logic                          n_reset;
logic                          apu_req_i;
logic [`VDEC_XLEN-1:0]         apu_operands_i [3];
logic [`VDEC_VL_W-1:0]         vl_i;
logic [1:0]                    vsew_i;
logic                          vlsu_ready_i;
logic                          apu_gnt_o, apu_rvalid_o, core_halt_o;
logic [`VDEC_XLEN-1:0]         scalar_operand1_o, scalar_operand2_o;
logic [`VDEC_IMM_W-1:0]        immediate_operand_o;
logic [`VDEC_VREG_AW-1:0]      vs1_addr_o, vs2_addr_o, vd_addr_o;
logic [`VDEC_LANES_LOG2-1:0]   elements_to_write_o;
logic [`VDEC_CNT_W-1:0]        cycle_count_o;
logic                          csr_write_o, preserve_vl_o, set_vl_max_o, vec_reg_write_o;
vdec_pkg::vreg_wb_src_t        vd_data_src_o;
vdec_pkg::pe_arith_op_t        pe_op_o;
vdec_pkg::pe_output_mode_t     output_mode_o;
vdec_pkg::pe_operand_t         operand_select_o;
vdec_pkg::apu_result_src_t     apu_result_select_o;
logic                          unsigned_immediate_o;
logic                          vlsu_en_o, vlsu_load_o, vlsu_store_o, vlsu_strided_o;
logic                          check_failed;
logic [5:0]                    arith_f6 [10];
logic [2:0]                    arith_f3 [3];

vector_decoder UUT (.*);

vdec_checks u_checks (
    .clk (clk), .n_reset (n_reset), .apu_req_i (apu_req_i),
    .instr_word_i (apu_operands_i[0]), .op1_word_i (apu_operands_i[1]),
    .op2_word_i (apu_operands_i[2]), .vl_i (vl_i), .vsew_i (vsew_i),
    .vlsu_ready_i (vlsu_ready_i), .apu_gnt_i (apu_gnt_o), .apu_rvalid_i (apu_rvalid_o),
    .core_halt_i (core_halt_o), .scalar_operand1_i (scalar_operand1_o),
    .scalar_operand2_i (scalar_operand2_o), .cycle_count_i (cycle_count_o),
    .vs1_addr_i (vs1_addr_o), .vs2_addr_i (vs2_addr_o), .vd_addr_i (vd_addr_o),
    .elements_to_write_i (elements_to_write_o), .csr_write_i (csr_write_o),
    .preserve_vl_i (preserve_vl_o), .set_vl_max_i (set_vl_max_o),
    .vec_reg_write_i (vec_reg_write_o), .vd_data_src_i (vd_data_src_o),
    .pe_op_i (pe_op_o), .output_mode_i (output_mode_o),
    .operand_select_i (operand_select_o), .apu_result_select_i (apu_result_select_o),
    .unsigned_immediate_i (unsigned_immediate_o),
    .immediate_operand_i (immediate_operand_o), .vlsu_en_i (vlsu_en_o),
    .vlsu_load_i (vlsu_load_o), .vlsu_store_i (vlsu_store_o),
    .vlsu_strided_i (vlsu_strided_o), .failed_o (check_failed)
);

initial
begin
    clk = 1'b0;
    forever #50 clk = ~clk;
end

task automatic stop_with_failure(input string why);
    $display("TEST FAIL");
    $fatal(1, "%s", why);
endtask

initial
begin
    @(posedge check_failed);
    stop_with_failure("a checker assertion failed");
end

function automatic logic [31:0] arith_word(input logic [5:0] f6, input logic [2:0] f3,
                                           input logic [6:0] opc);
    logic [4:0] vs2;
    logic [4:0] vs1;
    logic [4:0] vd;
    vs2 = 5'($urandom);
    vs1 = 5'($urandom);
    vd  = 5'($urandom);
    return {f6, 1'b1, vs2, vs1, f3, vd, opc};
endfunction

// one instruction from request to grant, optionally with VLSU stalls
task automatic run_instr(input logic [31:0] word, input bit stalls);
    int waited;
    waited = 0;
    @(negedge clk);
    vl_i           = 5'($urandom_range(16, 1));
    vsew_i         = 2'($urandom_range(1, 0));
    apu_req_i      = 1'b1;
    apu_operands_i = '{word, $urandom, $urandom};
    vlsu_ready_i   = stalls ? 1'($urandom) : 1'b1;
    @(negedge clk);
    apu_req_i = 1'b0;
    while (!apu_gnt_o)
    begin
        vlsu_ready_i = stalls ? 1'($urandom) : 1'b1;
        @(negedge clk);
        waited++;
        if (waited > 100)
            stop_with_failure("timeout waiting for the instruction to complete");
    end
endtask

initial
begin
    void'($urandom(32'h6c79));
    n_reset        = 1'b0;
    apu_req_i      = 1'b0;
    apu_operands_i = '{32'h0, 32'h0, 32'h0};
    vl_i           = 5'd4;
    vsew_i         = 2'd0;
    vlsu_ready_i   = 1'b1;
    arith_f6 = '{6'h00, 6'h02, 6'h05, 6'h07, 6'h09, 6'h0a, 6'h0b, 6'h25, 6'h28, 6'h29};
    arith_f3 = '{3'b000, 3'b100, 3'b011};
    repeat (8) @(negedge clk);
    n_reset = 1'b1;

    for (int i = 0; i < 30; i++)
        run_instr(arith_word(arith_f6[i % 10], arith_f3[i % 3], 7'h57), 1'b0);
    for (int i = 0; i < 6; i++)
        run_instr(arith_word((i % 2) ? 6'h07 : 6'h00, 3'b010, 7'h57), 1'b0);
    // vsetvli with every rs1/rd combination
    run_instr({1'b0, 11'($urandom), 5'd0, 3'b111, 5'd0, 7'h57}, 1'b0);
    run_instr({1'b0, 11'($urandom), 5'd0, 3'b111, 5'd9, 7'h57}, 1'b0);
    run_instr({1'b0, 11'($urandom), 5'd3, 3'b111, 5'd2, 7'h57}, 1'b0);
    run_instr({6'h10, 1'b1, 5'($urandom), 5'd0, 3'b010, 5'($urandom), 7'h57}, 1'b0);
    for (int i = 0; i < 4; i++)
        run_instr(arith_word(6'h17, 3'b011, 7'h57), 1'b0);
    for (int i = 0; i < 12; i++)
    begin
        run_instr(arith_word((i % 2) ? 6'h02 : 6'h00, 3'b111, 7'h07), 1'b1);
        run_instr(arith_word(6'h00, 3'b111, 7'h27), 1'b1);
    end

    repeat (2) @(negedge clk);
    if (check_failed)
    begin
        stop_with_failure("checks failed");
    end
    else
    begin
        $display("TEST PASS");
        $finish;
    end
end

endmodule

// File: verif/vdec_checks.sv
// vector decoder checker with a reference model of groups, indices and controls
`include "vdec_defines.svh"

module vdec_checks (
    input  logic                        clk,
    input  logic                        n_reset,
    input  logic                        apu_req_i,
    input  logic [`VDEC_XLEN-1:0]       instr_word_i,
    input  logic [`VDEC_XLEN-1:0]       op1_word_i,
    input  logic [`VDEC_XLEN-1:0]       op2_word_i,
    input  logic [`VDEC_VL_W-1:0]       vl_i,
    input  logic [1:0]                  vsew_i,
    input  logic                        vlsu_ready_i,
    input  logic                        apu_gnt_i,
    input  logic                        apu_rvalid_i,
    input  logic                        core_halt_i,
    input  logic [`VDEC_XLEN-1:0]       scalar_operand1_i,
    input  logic [`VDEC_XLEN-1:0]       scalar_operand2_i,
    input  logic [`VDEC_CNT_W-1:0]      cycle_count_i,
    input  logic [`VDEC_VREG_AW-1:0]    vs1_addr_i,
    input  logic [`VDEC_VREG_AW-1:0]    vs2_addr_i,
    input  logic [`VDEC_VREG_AW-1:0]    vd_addr_i,
    input  logic [`VDEC_LANES_LOG2-1:0] elements_to_write_i,
    input  logic                        csr_write_i,
    input  logic                        preserve_vl_i,
    input  logic                        set_vl_max_i,
    input  logic                        vec_reg_write_i,
    input  logic [1:0]                  vd_data_src_i,
    input  logic [2:0]                  pe_op_i,
    input  logic [1:0]                  output_mode_i,
    input  logic [1:0]                  operand_select_i,
    input  logic                        apu_result_select_i,
    input  logic                        unsigned_immediate_i,
    input  logic [`VDEC_IMM_W-1:0]      immediate_operand_i,
    input  logic                        vlsu_en_i,
    input  logic                        vlsu_load_i,
    input  logic                        vlsu_store_i,
    input  logic                        vlsu_strided_i,
    output logic                        failed_o
);

timeunit 1ns;
timeprecision 1ps;

logic                         m_exec;
logic [`VDEC_CNT_W-1:0]       m_cnt;
logic [31:0]                  m_instr;
logic [31:0]                  m_opnd1;
logic [31:0]                  m_opnd2;
logic [5:0]                   f6;
logic [2:0]                   f3;
logic [6:0]                   opc;
logic                         m_op, m_cfg, m_load, m_store, m_mvxs, m_arith, m_elem;
logic                         m_multi, m_mem, m_red, m_last;
logic [`VDEC_VL_W-1:0]        vl_m1;
logic [`VDEC_CNT_W-1:0]       m_g;
logic [`VDEC_VREG_AW-1:0]     m_off;
logic [`VDEC_VREG_AW-1:0]     exp_vd;
logic [`VDEC_LANES_LOG2-1:0]  exp_wr;
logic                         exp_uimm;
logic [2:0]                   exp_op;
logic [1:0]                   exp_mode;
logic [1:0]                   exp_sel;

initial failed_o = 1'b0;

task automatic log_mismatch(input string sig, input logic [31:0] got, input logic [31:0] exp);
    $display("** Error: %s = %h, expected %h", sig, got, exp);
    failed_o = 1'b1;
endtask

task automatic report_failure(input string what);
    $display("%s", what);
    failed_o = 1'b1;
endtask

// field slices of the captured word
assign f6  = m_instr[31:26];
assign f3  = m_instr[14:12];
assign opc = m_instr[6:0];

assign m_op    = (opc == 7'h57);
assign m_cfg   = m_op && (f3 == 3'b111);
assign m_load  = (opc == 7'h07) && (f3 == 3'b111);
assign m_store = (opc == 7'h27) && (f3 == 3'b111);
assign m_arith = m_op && !m_cfg;
assign m_mvxs  = m_arith && (f6 == 6'b010000);
assign m_elem  = m_arith && !m_mvxs;
assign m_red   = m_arith && (f3 == 3'b010);
assign m_multi = m_load || m_elem;
assign m_mem   = m_load || m_store;
assign vl_m1   = vl_i - 5'd1;
assign m_g     = m_multi ? vl_m1[3:2] : 2'd0;
assign m_last  = (m_cnt == m_g);
assign m_off   = (vsew_i == 2'd1) ? {2'b00, m_cnt, 1'b0} : {3'b000, m_cnt};
assign exp_vd  = (m_store || m_red) ? m_instr[11:7] : m_instr[11:7] + m_off;
assign exp_wr  = (m_multi && m_last) ? (m_red ? 2'd1 : vl_i[1:0]) : 2'd0;
// right shifts by an immediate take it unsigned
assign exp_uimm = m_arith && (f3 == 3'b011) && (f6 == 6'b101000 || f6 == 6'b101001);

always_comb
begin
    case (f6)
        6'b000010, 6'b000101, 6'b000111: exp_op = 3'd1;
        6'b001001: exp_op = 3'd2;
        6'b001010: exp_op = 3'd3;
        6'b001011: exp_op = 3'd4;
        6'b100101: exp_op = 3'd5;
        6'b101000: exp_op = 3'd6;
        6'b101001: exp_op = 3'd7;
        default:   exp_op = 3'd0;
    endcase
    exp_mode = (f6 == 6'b000101) ? 2'd1 : (f6 == 6'b000111) ? 2'd2 : 2'd0;
    case (f3)
        3'b100:  exp_sel = 2'd1;
        3'b011:  exp_sel = 2'd2;
        3'b010:  exp_sel = 2'd3;
        default: exp_sel = 2'd0;
    endcase
end

// one instruction at a time, one group per cycle unless stalled
always @(posedge clk or negedge n_reset)
begin
    if (!n_reset)
    begin
        m_exec  <= 1'b0;
        m_cnt   <= '0;
        m_instr <= '0;
        m_opnd1 <= '0;
        m_opnd2 <= '0;
    end
    else if (!m_exec)
    begin
        m_cnt <= '0;
        if (apu_req_i)
        begin
            m_exec  <= 1'b1;
            m_instr <= instr_word_i;
            m_opnd1 <= op1_word_i;
            m_opnd2 <= op2_word_i;
        end
    end
    else if (!m_mem || vlsu_ready_i)
    begin
        if (m_last)
            m_exec <= 1'b0;
        else
            m_cnt <= m_cnt + 2'd1;
    end
end

a_idle: assert property (@(posedge clk) !m_exec |-> apu_gnt_i && !apu_rvalid_i
    && !core_halt_i && !vec_reg_write_i && !csr_write_i && !vlsu_en_i)
    else report_failure("outputs not idle outside an instruction");
a_halt: assert property (@(posedge clk) disable iff (!n_reset) core_halt_i == m_exec)
    else log_mismatch("core_halt_o", 32'($sampled(core_halt_i)), 32'($sampled(m_exec)));
a_rvalid: assert property (@(posedge clk) disable iff (!n_reset)
    apu_rvalid_i == (m_exec && m_last && (!m_mem || vlsu_ready_i)))
    else report_failure("apu_rvalid_o pulse at the wrong cycle");
a_opnd1: assert property (@(posedge clk) disable iff (!n_reset)
    m_exec |-> scalar_operand1_i == m_opnd1)
    else log_mismatch("scalar_operand1_o", $sampled(scalar_operand1_i), $sampled(m_opnd1));
a_opnd2: assert property (@(posedge clk) disable iff (!n_reset)
    m_exec |-> scalar_operand2_i == m_opnd2)
    else log_mismatch("scalar_operand2_o", $sampled(scalar_operand2_i), $sampled(m_opnd2));
a_count: assert property (@(posedge clk) disable iff (!n_reset) m_exec |-> cycle_count_i == m_cnt)
    else log_mismatch("cycle_count_o", 32'($sampled(cycle_count_i)), 32'($sampled(m_cnt)));
a_vs1: assert property (@(posedge clk) disable iff (!n_reset)
    m_exec && !m_cfg |-> vs1_addr_i == m_instr[19:15] + m_off)
    else log_mismatch("vs1_addr_o", 32'($sampled(vs1_addr_i)),
        32'($sampled(m_instr[19:15] + m_off)));
a_vs2: assert property (@(posedge clk) disable iff (!n_reset)
    m_exec && !m_cfg |-> vs2_addr_i == m_instr[24:20] + m_off)
    else log_mismatch("vs2_addr_o", 32'($sampled(vs2_addr_i)),
        32'($sampled(m_instr[24:20] + m_off)));
a_vd: assert property (@(posedge clk) disable iff (!n_reset)
    m_exec && !m_cfg |-> vd_addr_i == exp_vd)
    else log_mismatch("vd_addr_o", 32'($sampled(vd_addr_i)), 32'($sampled(exp_vd)));
a_ewrite: assert property (@(posedge clk) disable iff (!n_reset)
    m_exec |-> elements_to_write_i == exp_wr)
    else log_mismatch("elements_to_write_o", 32'($sampled(elements_to_write_i)),
        32'($sampled(exp_wr)));
a_pe_op: assert property (@(posedge clk) disable iff (!n_reset) m_exec && m_arith |->
    pe_op_i == exp_op && output_mode_i == exp_mode && operand_select_i == exp_sel)
    else report_failure("PE operation, output mode or operand select decoded wrongly");
a_uimm: assert property (@(posedge clk) disable iff (!n_reset)
    m_exec |-> unsigned_immediate_i == exp_uimm)
    else log_mismatch("unsigned_immediate_o", 32'($sampled(unsigned_immediate_i)),
        32'($sampled(exp_uimm)));
a_wen: assert property (@(posedge clk) disable iff (!n_reset)
    m_exec |-> vec_reg_write_i == m_elem)
    else log_mismatch("vec_reg_write_o", 32'($sampled(vec_reg_write_i)),
        32'($sampled(m_elem)));
a_csr: assert property (@(posedge clk) disable iff (!n_reset) m_exec |-> csr_write_i == m_cfg)
    else log_mismatch("csr_write_o", 32'($sampled(csr_write_i)), 32'($sampled(m_cfg)));
a_cfg: assert property (@(posedge clk) disable iff (!n_reset) m_exec && m_cfg |->
    immediate_operand_i == m_instr[30:20]
    && preserve_vl_i == (m_instr[19:15] == 5'd0 && m_instr[11:7] == 5'd0)
    && set_vl_max_i == (m_instr[19:15] == 5'd0 && m_instr[11:7] != 5'd0))
    else report_failure("vsetvli immediate or vl mode decoded wrongly");
a_mvxs: assert property (@(posedge clk) disable iff (!n_reset)
    m_exec && m_mvxs |-> apu_result_select_i == 1'b1)
    else log_mismatch("apu_result_select_o", 32'($sampled(apu_result_select_i)), 32'd1);
a_mvvi: assert property (@(posedge clk) disable iff (!n_reset)
    m_exec && m_arith && f6 == 6'b010111 |-> vd_data_src_i == 2'd1
    && immediate_operand_i == {6'b0, m_instr[19:15]})
    else report_failure("vmv.v.i writeback source or immediate wrong");
a_load: assert property (@(posedge clk) disable iff (!n_reset) m_exec && m_load |->
    vlsu_en_i && vlsu_load_i && vd_data_src_i == 2'd2
    && vlsu_strided_i == (m_instr[28:26] != 3'd0))
    else report_failure("vector load controls wrong");
a_store: assert property (@(posedge clk) disable iff (!n_reset) m_exec && m_store |->
    vlsu_en_i && vlsu_store_i && !vlsu_load_i)
    else report_failure("vector store controls wrong");

endmodule

// File: hdl/vector_decoder.sv
// vector accelerator decoder top joining sequencer, op decoder and index generator
`include "vdec_defines.svh"

module vector_decoder (
    input  logic                      clk,
    input  logic                      n_reset,
    input  logic                      apu_req_i,
    input  logic [`VDEC_XLEN-1:0]     apu_operands_i [3],
    input  logic [`VDEC_VL_W-1:0]     vl_i,
    input  logic [1:0]                vsew_i,
    input  logic                      vlsu_ready_i,
    output logic                      apu_gnt_o,
    output logic                      apu_rvalid_o,
    output logic                      core_halt_o,
    output logic [`VDEC_XLEN-1:0]     scalar_operand1_o,
    output logic [`VDEC_XLEN-1:0]     scalar_operand2_o,
    output logic [`VDEC_IMM_W-1:0]    immediate_operand_o,
    output logic [`VDEC_VREG_AW-1:0]  vs1_addr_o,
    output logic [`VDEC_VREG_AW-1:0]  vs2_addr_o,
    output logic [`VDEC_VREG_AW-1:0]  vd_addr_o,
    output logic [`VDEC_LANES_LOG2-1:0] elements_to_write_o,
    output logic [`VDEC_CNT_W-1:0]    cycle_count_o,
    output logic                      csr_write_o,
    output logic                      preserve_vl_o,
    output logic                      set_vl_max_o,
    output logic                      vec_reg_write_o,
    output vdec_pkg::vreg_wb_src_t    vd_data_src_o,
    output vdec_pkg::pe_arith_op_t    pe_op_o,
    output vdec_pkg::pe_output_mode_t output_mode_o,
    output vdec_pkg::pe_operand_t     operand_select_o,
    output vdec_pkg::apu_result_src_t apu_result_select_o,
    output logic                      unsigned_immediate_o,
    output logic                      vlsu_en_o,
    output logic                      vlsu_load_o,
    output logic                      vlsu_store_o,
    output logic                      vlsu_strided_o
);

vdec_pkg::vinstr_u instr;
logic              exec;
logic              last_cycle;
logic              multi_cycle;
logic              mem_access;
logic              fix_vd;

apu_sequencer u_apu_sequencer (
    .clk               (clk),
    .n_reset           (n_reset),
    .apu_req_i         (apu_req_i),
    .apu_operands_i    (apu_operands_i),
    .vl_i              (vl_i),
    .multi_cycle_i     (multi_cycle),
    .mem_access_i      (mem_access),
    .vlsu_ready_i      (vlsu_ready_i),
    .apu_gnt_o         (apu_gnt_o),
    .apu_rvalid_o      (apu_rvalid_o),
    .core_halt_o       (core_halt_o),
    .instr_o           (instr),
    .scalar_operand1_o (scalar_operand1_o),
    .scalar_operand2_o (scalar_operand2_o),
    .exec_o            (exec),
    .cycle_count_o     (cycle_count_o),
    .last_cycle_o      (last_cycle)
);

vop_decoder u_vop_decoder (
    .instr_i              (instr),
    .exec_i               (exec),
    .csr_write_o          (csr_write_o),
    .preserve_vl_o        (preserve_vl_o),
    .set_vl_max_o         (set_vl_max_o),
    .vec_reg_write_o      (vec_reg_write_o),
    .vd_data_src_o        (vd_data_src_o),
    .pe_op_o              (pe_op_o),
    .output_mode_o        (output_mode_o),
    .operand_select_o     (operand_select_o),
    .apu_result_select_o  (apu_result_select_o),
    .unsigned_immediate_o (unsigned_immediate_o),
    .immediate_operand_o  (immediate_operand_o),
    .multi_cycle_o        (multi_cycle),
    .mem_access_o         (mem_access),
    .fix_vd_o             (fix_vd),
    .vlsu_en_o            (vlsu_en_o),
    .vlsu_load_o          (vlsu_load_o),
    .vlsu_store_o         (vlsu_store_o),
    .vlsu_strided_o       (vlsu_strided_o)
);

vreg_index_gen u_vreg_index_gen (
    .instr_i             (instr),
    .cycle_count_i       (cycle_count_o),
    .last_cycle_i        (last_cycle),
    .multi_cycle_i       (multi_cycle),
    .fix_vd_i            (fix_vd),
    .operand_select_i    (operand_select_o),
    .vl_i                (vl_i),
    .vsew_i              (vsew_i),
    .vs1_addr_o          (vs1_addr_o),
    .vs2_addr_o          (vs2_addr_o),
    .vd_addr_o           (vd_addr_o),
    .elements_to_write_o (elements_to_write_o)
);

endmodule

// File: hdl/vreg_index_gen.sv
// per-group vector register indices and element write count
`include "vdec_defines.svh"

module vreg_index_gen (
    input  vdec_pkg::vinstr_u              instr_i,
    input  logic [`VDEC_CNT_W-1:0]         cycle_count_i,
    input  logic                           last_cycle_i,
    input  logic                           multi_cycle_i,
    input  logic                           fix_vd_i,
    input  vdec_pkg::pe_operand_t          operand_select_i,
    input  logic [`VDEC_VL_W-1:0]          vl_i,
    input  logic [1:0]                     vsew_i,
    output logic [`VDEC_VREG_AW-1:0]       vs1_addr_o,
    output logic [`VDEC_VREG_AW-1:0]       vs2_addr_o,
    output logic [`VDEC_VREG_AW-1:0]       vd_addr_o,
    output logic [`VDEC_LANES_LOG2-1:0]    elements_to_write_o
);

logic [`VDEC_VREG_AW-1:0] offset;

// 16-bit elements fill two registers per group
always_comb
begin
    if (vsew_i == 2'd1)
        offset = {{(`VDEC_VREG_AW-`VDEC_CNT_W-1){1'b0}}, cycle_count_i, 1'b0};
    else
        offset = {{(`VDEC_VREG_AW-`VDEC_CNT_W){1'b0}}, cycle_count_i};
end

assign vs1_addr_o = instr_i.arith.vs1 + offset;
assign vs2_addr_o = instr_i.arith.vs2 + offset;
assign vd_addr_o  = fix_vd_i ? instr_i.arith.vd : instr_i.arith.vd + offset;

always_comb
begin
    elements_to_write_o = '0;
    if (multi_cycle_i && last_cycle_i)
    begin
        // a reduction lands in a single element
        if (operand_select_i == vdec_pkg::PE_OPERAND_RIPPLE)
            elements_to_write_o = 1;
        else
            elements_to_write_o = vl_i[`VDEC_LANES_LOG2-1:0];
    end
end

endmodule

// File: hdl/vop_decoder.sv
// decodes the captured vector instruction into PE, CSR and VLSU controls
`include "vdec_defines.svh"

module vop_decoder (
    input  vdec_pkg::vinstr_u         instr_i,
    input  logic                      exec_i,
    output logic                      csr_write_o,
    output logic                      preserve_vl_o,
    output logic                      set_vl_max_o,
    output logic                      vec_reg_write_o,
    output vdec_pkg::vreg_wb_src_t    vd_data_src_o,
    output vdec_pkg::pe_arith_op_t    pe_op_o,
    output vdec_pkg::pe_output_mode_t output_mode_o,
    output vdec_pkg::pe_operand_t     operand_select_o,
    output vdec_pkg::apu_result_src_t apu_result_select_o,
    output logic                      unsigned_immediate_o,
    output logic [`VDEC_IMM_W-1:0]    immediate_operand_o,
    output logic                      multi_cycle_o,
    output logic                      mem_access_o,
    output logic                      fix_vd_o,
    output logic                      vlsu_en_o,
    output logic                      vlsu_load_o,
    output logic                      vlsu_store_o,
    output logic                      vlsu_strided_o
);

// width field value used by the vector load/store forms
localparam logic [2:0] VMEM_WIDTH = 3'b111;

logic is_cfg;
logic is_load;
logic is_store;
logic elementwise;

assign is_cfg   = (instr_i.cfg.opcode == vdec_pkg::V_MAJOR_OP_V)
               && (instr_i.cfg.funct3 == vdec_pkg::V_OPCFG);
assign is_load  = exec_i && (instr_i.arith.opcode == vdec_pkg::V_MAJOR_LOAD_FP)
               && (instr_i.arith.funct3 == VMEM_WIDTH);
assign is_store = exec_i && (instr_i.arith.opcode == vdec_pkg::V_MAJOR_STORE_FP)
               && (instr_i.arith.funct3 == VMEM_WIDTH);

// OP-V instructions that run over the whole vector
assign elementwise = exec_i && (instr_i.arith.opcode == vdec_pkg::V_MAJOR_OP_V) && !is_cfg
                  && (instr_i.arith.funct6 != vdec_pkg::VF6_WXUNARY0);

// zimm for vsetvli, zero extended vs1 field otherwise
assign immediate_operand_o = is_cfg ? instr_i.cfg.zimm
                           : {{(`VDEC_IMM_W-`VDEC_VREG_AW){1'b0}}, instr_i.arith.vs1};

assign vlsu_en_o      = is_load || is_store;
assign vlsu_load_o    = is_load;
assign vlsu_store_o   = is_store;
// nonzero mop selects strided addressing
assign vlsu_strided_o = is_load && (instr_i.arith.funct6[2:0] != 3'b000);
assign mem_access_o   = is_load || is_store;
assign multi_cycle_o  = is_load || elementwise;
assign vec_reg_write_o = elementwise;

always_comb
begin
    csr_write_o          = 1'b0;
    preserve_vl_o        = 1'b0;
    set_vl_max_o         = 1'b0;
    vd_data_src_o        = vdec_pkg::VREG_WB_SRC_ARITH;
    pe_op_o              = vdec_pkg::PE_ARITH_ADD;
    output_mode_o        = vdec_pkg::PE_OP_MODE_RESULT;
    operand_select_o     = vdec_pkg::PE_OPERAND_VS1;
    apu_result_select_o  = vdec_pkg::APU_RESULT_SRC_VL;
    unsigned_immediate_o = 1'b0;
    fix_vd_o             = 1'b0;

    if (is_load)
        vd_data_src_o = vdec_pkg::VREG_WB_SRC_MEMORY;
    else if (is_store)
        fix_vd_o = 1'b1;
    else if (exec_i && is_cfg)
    begin
        csr_write_o = 1'b1;
        // rs1 of x0 keeps vl, or sets vlmax when rd is written
        if (instr_i.cfg.rs1 == '0)
        begin
            preserve_vl_o = (instr_i.cfg.rd == '0);
            set_vl_max_o  = (instr_i.cfg.rd != '0);
        end
    end
    else if (exec_i && (instr_i.arith.opcode == vdec_pkg::V_MAJOR_OP_V))
    begin
        // operand source from funct3, reductions ripple through the lanes
        case (instr_i.arith.funct3)
            vdec_pkg::V_OPIVX:
                operand_select_o = vdec_pkg::PE_OPERAND_SCALAR;
            vdec_pkg::V_OPIVI:
                operand_select_o = vdec_pkg::PE_OPERAND_IMMEDIATE;
            vdec_pkg::V_OPMVV:
            begin
                operand_select_o = vdec_pkg::PE_OPERAND_RIPPLE;
                fix_vd_o         = 1'b1;
            end
            default:
                operand_select_o = vdec_pkg::PE_OPERAND_VS1;
        endcase

        case (instr_i.arith.funct6)
            vdec_pkg::VF6_SUB:
                pe_op_o = vdec_pkg::PE_ARITH_SUB;
            vdec_pkg::VF6_MIN:
            begin
                pe_op_o       = vdec_pkg::PE_ARITH_SUB;
                output_mode_o = vdec_pkg::PE_OP_MODE_PASS_MIN;
            end
            vdec_pkg::VF6_MAX:
            begin
                pe_op_o       = vdec_pkg::PE_ARITH_SUB;
                output_mode_o = vdec_pkg::PE_OP_MODE_PASS_MAX;
            end
            vdec_pkg::VF6_AND:
                pe_op_o = vdec_pkg::PE_ARITH_AND;
            vdec_pkg::VF6_OR:
                pe_op_o = vdec_pkg::PE_ARITH_OR;
            vdec_pkg::VF6_XOR:
                pe_op_o = vdec_pkg::PE_ARITH_XOR;
            vdec_pkg::VF6_WXUNARY0:
                apu_result_select_o = vdec_pkg::APU_RESULT_SRC_VS2_0;
            vdec_pkg::VF6_MV:
                vd_data_src_o = vdec_pkg::VREG_WB_SRC_SCALAR;
            vdec_pkg::VF6_SLL:
                pe_op_o = vdec_pkg::PE_ARITH_LSHIFT;
            vdec_pkg::VF6_SRL:
            begin
                pe_op_o              = vdec_pkg::PE_ARITH_RSHIFT_LOG;
                unsigned_immediate_o = (instr_i.arith.funct3 == vdec_pkg::V_OPIVI);
            end
            vdec_pkg::VF6_SRA:
            begin
                pe_op_o              = vdec_pkg::PE_ARITH_RSHIFT_AR;
                unsigned_immediate_o = (instr_i.arith.funct3 == vdec_pkg::V_OPIVI);
            end
            default:
                pe_op_o = vdec_pkg::PE_ARITH_ADD;
        endcase
    end

    // only the three supported major opcodes ever reach EXEC
    if (exec_i)
        a_major_opcode: assert (instr_i.arith.opcode inside {vdec_pkg::V_MAJOR_LOAD_FP,
            vdec_pkg::V_MAJOR_STORE_FP, vdec_pkg::V_MAJOR_OP_V})
        else $error("unrecognised major opcode %h", instr_i.arith.opcode);
end

endmodule

// File: hdl/apu_sequencer.sv
// APU request/grant FSM with operand capture and element group counter
`include "vdec_defines.svh"

module apu_sequencer (
    input  logic                   clk,
    input  logic                   n_reset,
    input  logic                   apu_req_i,
    input  logic [`VDEC_XLEN-1:0]  apu_operands_i [3],
    input  logic [`VDEC_VL_W-1:0]  vl_i,
    input  logic                   multi_cycle_i,
    input  logic                   mem_access_i,
    input  logic                   vlsu_ready_i,
    output logic                   apu_gnt_o,
    output logic                   apu_rvalid_o,
    output logic                   core_halt_o,
    output vdec_pkg::vinstr_u      instr_o,
    output logic [`VDEC_XLEN-1:0]  scalar_operand1_o,
    output logic [`VDEC_XLEN-1:0]  scalar_operand2_o,
    output logic                   exec_o,
    output logic [`VDEC_CNT_W-1:0] cycle_count_o,
    output logic                   last_cycle_o
);

typedef enum logic {
    WAIT,
    EXEC
} state_t;

state_t                  state_q;
state_t                  state_d;
vdec_pkg::vinstr_u       instr_q;
logic [`VDEC_XLEN-1:0]   op1_q;
logic [`VDEC_XLEN-1:0]   op2_q;
logic [`VDEC_CNT_W-1:0]  cnt_q;
logic [`VDEC_VL_W-1:0]   vl_m1;
logic [`VDEC_CNT_W-1:0]  final_group;
logic                    accept;
logic                    step;
logic                    finish;

// last group index, four elements per group
assign vl_m1       = vl_i - 1'b1;
assign final_group = multi_cycle_i ? vl_m1[`VDEC_LANES_LOG2 +: `VDEC_CNT_W] : '0;

assign exec_o       = (state_q == EXEC);
assign accept       = (state_q == WAIT) && apu_req_i;
// memory instructions only move on when the VLSU is ready
assign step         = !mem_access_i || vlsu_ready_i;
assign last_cycle_o = (cnt_q == final_group);
assign finish       = exec_o && last_cycle_o && step;

assign apu_gnt_o    = (state_q == WAIT);
assign apu_rvalid_o = finish;
assign core_halt_o  = exec_o;

always_comb
begin
    state_d = state_q;
    case (state_q)
        WAIT:
        begin
            if (apu_req_i)
                state_d = EXEC;
        end
        EXEC:
        begin
            if (finish)
                state_d = WAIT;
        end
        default:
            state_d = WAIT;
    endcase
end

always_ff @(posedge clk or negedge n_reset)
begin
    if (!n_reset)
    begin
        state_q <= WAIT;
        instr_q <= '0;
        cnt_q   <= '0;
    end
    else
    begin
        state_q <= state_d;
        if (accept)
            instr_q <= apu_operands_i[0];
        // back to group zero once the instruction completes
        if (!exec_o || finish)
            cnt_q <= '0;
        else if (step)
            cnt_q <= cnt_q + 1'b1;
    end
end

// scalar operands for the PEs, captured with the instruction
always_ff @(posedge clk)
begin
    if (accept)
    begin
        op1_q <= apu_operands_i[1];
        op2_q <= apu_operands_i[2];
    end
end

assign instr_o           = instr_q;
assign scalar_operand1_o = op1_q;
assign scalar_operand2_o = op2_q;
assign cycle_count_o     = cnt_q;

// completion only from EXEC and always followed by WAIT
a_rvalid_in_exec: assert property (@(posedge clk) disable iff (!n_reset)
    apu_rvalid_o |-> exec_o ##1 !exec_o);

// group counter stays within the vl derived by the decoder
a_count_bound: assert property (@(posedge clk) disable iff (!n_reset)
    exec_o |-> cycle_count_o <= final_group);

endmodule

// File: hdl/vdec_pkg.sv
// shared instruction formats and control encodings for the vector decoder
`include "vdec_defines.svh"

package vdec_pkg;

    typedef enum logic [2:0] {
        V_OPIVV = 3'b000,
        V_OPMVV = 3'b010,
        V_OPIVI = 3'b011,
        V_OPIVX = 3'b100,
        V_OPMVX = 3'b110,
        V_OPCFG = 3'b111
    } vfunct3_t;

    typedef enum logic [6:0] {
        V_MAJOR_LOAD_FP  = 7'b0000111,
        V_MAJOR_STORE_FP = 7'b0100111,
        V_MAJOR_OP_V     = 7'b1010111
    } vmajor_t;

    typedef enum logic [5:0] {
        VF6_ADD       = 6'b000000,
        VF6_SUB       = 6'b000010,
        VF6_MIN       = 6'b000101,
        VF6_MAX       = 6'b000111,
        VF6_AND       = 6'b001001,
        VF6_OR        = 6'b001010,
        VF6_XOR       = 6'b001011,
        VF6_WXUNARY0  = 6'b010000,
        VF6_MV        = 6'b010111,
        VF6_SLL       = 6'b100101,
        VF6_SRL       = 6'b101000,
        VF6_SRA       = 6'b101001
    } vfunct6_t;

    typedef enum logic [2:0] {
        PE_ARITH_ADD,
        PE_ARITH_SUB,
        PE_ARITH_AND,
        PE_ARITH_OR,
        PE_ARITH_XOR,
        PE_ARITH_LSHIFT,
        PE_ARITH_RSHIFT_LOG,
        PE_ARITH_RSHIFT_AR
    } pe_arith_op_t;

    typedef enum logic [1:0] {
        PE_OP_MODE_RESULT,
        PE_OP_MODE_PASS_MIN,
        PE_OP_MODE_PASS_MAX
    } pe_output_mode_t;

    typedef enum logic [1:0] {
        PE_OPERAND_VS1,
        PE_OPERAND_SCALAR,
        PE_OPERAND_IMMEDIATE,
        PE_OPERAND_RIPPLE
    } pe_operand_t;

    typedef enum logic [1:0] {
        VREG_WB_SRC_ARITH,
        VREG_WB_SRC_SCALAR,
        VREG_WB_SRC_MEMORY
    } vreg_wb_src_t;

    typedef enum logic {
        APU_RESULT_SRC_VL,
        APU_RESULT_SRC_VS2_0
    } apu_result_src_t;

    // OP-V, load and store layout
    typedef struct packed {
        logic [5:0]               funct6;
        logic                     vm;
        logic [`VDEC_VREG_AW-1:0] vs2;
        logic [`VDEC_VREG_AW-1:0] vs1;
        vfunct3_t                 funct3;
        logic [`VDEC_VREG_AW-1:0] vd;
        vmajor_t                  opcode;
    } varith_fmt_t;

    // vsetvli layout
    typedef struct packed {
        logic                     top;
        logic [`VDEC_IMM_W-1:0]   zimm;
        logic [`VDEC_VREG_AW-1:0] rs1;
        vfunct3_t                 funct3;
        logic [`VDEC_VREG_AW-1:0] rd;
        vmajor_t                  opcode;
    } vcfg_fmt_t;

    typedef union packed {
        varith_fmt_t arith;
        vcfg_fmt_t   cfg;
    } vinstr_u;

endpackage

// File: hdl/vdec_defines.svh
// vector decoder widths and per-cycle lane count
`ifndef VDEC_DEFINES_SVH
`define VDEC_DEFINES_SVH

// scalar operand and instruction word width
`define VDEC_XLEN 32

// vector register file has 32 entries
`define VDEC_VREG_AW 5

// vector length register width
`define VDEC_VL_W 5

// element group counter
// wide enough for the largest vl at four lanes
`define VDEC_CNT_W 2

// four elements handled per cycle
`define VDEC_LANES_LOG2 2

// zimm field of vsetvli
// the simm5/uimm5 field of OP-V is zero extended to this width
`define VDEC_IMM_W 11

`endif
